// File: include/etx_regmap.svh
/*
 * word indices of the tx configuration register map
 */
`ifndef ETX_REGMAP_SVH
`define ETX_REGMAP_SVH

// index = mi_addr[RFAW+1:2], byte offset bits ignored
// left unsized so they compare against any RFAW

// version word, 16 bits, writable
`define E_VERSION   0

// chip id, 12 bits, reset DEFAULT_CHIPID
`define E_CHIPID    1

// tx config, 11 bits
`define ETX_CFG     2

// sticky events + live sent count, read only
`define ETX_STATUS  3

// static pin levels for gpio mode, 9 bits
`define ETX_GPIO    4

`endif

// File: verilog/etx_pkg.sv
/*
 * shared types for the mesh link transmit path
 * mesh packet, decoded tx config, stage events, status width
 */
`default_nettype none

package etx_pkg;

   // ####################
   // mesh packet
   // ####################

   // one mesh transaction, access strobe travels beside it
   typedef struct packed {
      logic        write;      // 1 = write, 0 = read request
      logic [1:0]  datamode;   // transfer size
      logic [3:0]  ctrlmode;   // emesh ctrl tag
      logic [31:0] dst_addr;   // upper 12 bits = target chip id
      logic [31:0] data;
      logic [31:0] src_addr;   // return address for reads
   } emesh_packet_t;           // 103 bits

   // ####################
   // static config
   // ####################

   // fields decoded from the raw ETX_CFG / ETX_GPIO / E_CHIPID words
   typedef struct packed {
      logic        tx_enable;        // off = drop everything
      logic        remap_enable;     // cfg[3:2] == 01
      logic [3:0]  ctrlmode;         // override value
      logic        ctrlmode_bypass;  // use ctrlmode above
      logic        gpio_enable;      // pins driven static
      logic        tp_enable;        // pins toggle 155/0aa
      logic [8:0]  gpio_data;        // static pin levels
      logic [11:0] chipid;           // this chip, for remap
   } tx_cfg_t;                       // 30 bits

   // ####################
   // stage events
   // ####################

   // low three bits line up with status bits 2:0
   typedef struct packed {
      logic [7:0] count;          // live sent count, etx_pins only
      logic       remapped;       // status bit 2
      logic       drop_mode;      // status bit 1, gpio/test drop
      logic       drop_disabled;  // status bit 0, tx off drop
   } tx_event_t;

   // status word width, zero above bit 10
   localparam int ETX_STATUS_W = 16;

endpackage

`default_nettype wire

// File: verilog/etx_cfg.sv
/*
 * tx configuration register file
 * address decode, five registers, sticky status, registered readback
 */
`timescale 1ns/1ps
`default_nettype none

`include "etx_regmap.svh"

module etx_cfg #(
   parameter int          RFAW            = 6,        // register index width
   parameter logic [11:0] DEFAULT_CHIPID  = 12'h808,
   parameter logic [15:0] DEFAULT_VERSION = 16'h0000
) (
   input  logic               clk,
   input  logic               reset,
   // memory interface
   input  logic               mi_en,
   input  logic               mi_we,
   input  logic [RFAW+1:0]    mi_addr,   // byte address, bits 1:0 ignored
   input  logic [31:0]        mi_din,
   output logic [31:0]        mi_dout,   // valid the cycle after a read
   // decoded config out, events in
   output etx_pkg::tx_cfg_t   cfg,
   input  etx_pkg::tx_event_t ev_remap,
   input  etx_pkg::tx_event_t ev_pins
);
   import etx_pkg::*;

   logic [RFAW-1:0]         reg_idx;
   logic                    mi_write;
   logic                    mi_read;
   logic                    version_we;
   logic                    chipid_we;
   logic                    config_we;
   logic                    gpio_we;
   logic [15:0]             version_reg;
   logic [11:0]             chipid_reg;
   logic [10:0]             config_reg;  // raw ETX_CFG bits
   logic [8:0]              gpio_reg;
   logic [2:0]              sticky_reg;  // drop_disabled, drop_mode, remapped
   tx_event_t               ev_all;
   logic [ETX_STATUS_W-1:0] status_word;

   // ####################
   // address decode
   // ####################

   assign reg_idx  = mi_addr[RFAW+1:2];  // word index
   assign mi_write = mi_en & mi_we;
   assign mi_read  = mi_en & ~mi_we;

   // per register write enables, status has none
   assign version_we = mi_write & (reg_idx == `E_VERSION);
   assign chipid_we  = mi_write & (reg_idx == `E_CHIPID);
   assign config_we  = mi_write & (reg_idx == `ETX_CFG);
   assign gpio_we    = mi_write & (reg_idx == `ETX_GPIO);

   // ####################
   // registers
   // ####################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         version_reg <= DEFAULT_VERSION;
         chipid_reg  <= DEFAULT_CHIPID;
         config_reg  <= '0;
         gpio_reg    <= '0;
      end
      else
      begin
         if (version_we)
            version_reg <= mi_din[15:0];
         if (chipid_we)
            chipid_reg <= mi_din[11:0];
         if (config_we)
            config_reg <= mi_din[10:0];  // bit 1 (mmu) kept for readback only
         if (gpio_we)
            gpio_reg <= mi_din[8:0];
      end
   end

   // field decode, same bit layout as the link spec
   assign cfg.tx_enable       = config_reg[0];
   assign cfg.remap_enable    = (config_reg[3:2] == 2'b01);
   assign cfg.ctrlmode        = config_reg[7:4];
   assign cfg.ctrlmode_bypass = config_reg[8];
   assign cfg.gpio_enable     = (config_reg[10:9] == 2'b01);
   assign cfg.tp_enable       = (config_reg[10:9] == 2'b10);  // 11 = neither
   assign cfg.gpio_data       = gpio_reg;
   assign cfg.chipid          = chipid_reg;

   // ####################
   // status
   // ####################

   // each stage only drives its own bits, rest are zero
   assign ev_all = ev_remap | ev_pins;

   // sticky until reset
   always_ff @(posedge clk)
   begin
      if (reset)
         sticky_reg <= '0;
      else
         sticky_reg <= sticky_reg | {ev_all.remapped, ev_all.drop_mode,
                                     ev_all.drop_disabled};
   end

   // events low, live count above, zero on top
   assign status_word = {{(ETX_STATUS_W - 11){1'b0}}, ev_all.count, sticky_reg};

   // ####################
   // readback
   // ####################

   // pipelined mux, zero whenever no read is in flight
   always_ff @(posedge clk)
   begin
      if (reset)
         mi_dout <= '0;
      else if (mi_read)
      begin
         case (reg_idx)
            `E_VERSION:  mi_dout <= {16'b0, version_reg};
            `E_CHIPID:   mi_dout <= {20'b0, chipid_reg};
            `ETX_CFG:    mi_dout <= {21'b0, config_reg};
            `ETX_STATUS: mi_dout <= {{(32 - ETX_STATUS_W){1'b0}}, status_word};
            `ETX_GPIO:   mi_dout <= {23'b0, gpio_reg};
            default:     mi_dout <= '0;  // unmapped
         endcase
      end
      else
         mi_dout <= '0;
   end

endmodule

`default_nettype wire

// File: verilog/etx_remap.sv
/*
 * tx execute stage, one packet per cycle
 * enable drop, chip id remap, ctrlmode override
 */
`timescale 1ns/1ps
`default_nettype none

module etx_remap (
   input  logic                  clk,
   input  logic                  reset,
   input  etx_pkg::tx_cfg_t      cfg,
   // from mesh
   input  logic                  in_access,  // one cycle per packet
   input  etx_pkg::emesh_packet_t in_packet,
   // to result stage
   output logic                  st_access,
   output etx_pkg::emesh_packet_t st_packet,
   output etx_pkg::tx_event_t    ev
);
   import etx_pkg::*;

   emesh_packet_t pkt_next;       // modified packet before the stage reg
   logic          drop_dis_q;
   logic          remapped_q;

   // ####################
   // packet rewrite
   // ####################

   always_comb
   begin
      pkt_next = in_packet;
      // upper 12 destination bits select the target chip
      if (cfg.remap_enable)
         pkt_next.dst_addr[31:20] = cfg.chipid;
      if (cfg.ctrlmode_bypass)
         pkt_next.ctrlmode = cfg.ctrlmode;  // forced tag
   end

   // ####################
   // stage register
   // ####################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         st_access  <= 1'b0;
         drop_dis_q <= 1'b0;
         remapped_q <= 1'b0;
      end
      else
      begin
         st_access  <= in_access & cfg.tx_enable;   // tx off, nothing passes
         drop_dis_q <= in_access & ~cfg.tx_enable;
         remapped_q <= in_access & cfg.tx_enable & cfg.remap_enable;
      end
   end

   // payload, only loads on a strobe
   always_ff @(posedge clk)
   begin
      if (in_access)
         st_packet <= pkt_next;
   end

   // one cycle pulses, count and drop_mode belong to etx_pins
   assign ev = '{count:         8'd0,
                 remapped:      remapped_q,
                 drop_mode:     1'b0,
                 drop_disabled: drop_dis_q};

endmodule

`default_nettype wire

// File: verilog/etx_pins.sv
/*
 * tx result stage
 * output mode select, test pattern, sent packet counter
 */
`timescale 1ns/1ps
`default_nettype none

module etx_pins (
   input  logic                   clk,
   input  logic                   reset,
   input  etx_pkg::tx_cfg_t       cfg,
   // from execute stage
   input  logic                   st_access,
   input  etx_pkg::emesh_packet_t st_packet,
   // link side
   output logic                   tx_out_access,
   output etx_pkg::emesh_packet_t tx_out_packet,
   output logic [8:0]             tx_pins,
   output etx_pkg::tx_event_t     ev
);
   localparam logic [8:0] TP_A = 9'h155;  // first pattern word
   localparam logic [8:0] TP_B = 9'h0AA;

   logic       mode_drop;    // pins owned by gpio or test pattern
   logic       tp_phase;     // 0 = TP_A next
   logic [7:0] sent_cnt;     // wraps at 256
   logic       drop_mode_q;

   assign mode_drop = cfg.gpio_enable | cfg.tp_enable;

   // ####################
   // packet path
   // ####################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_out_access <= 1'b0;
         drop_mode_q   <= 1'b0;
         sent_cnt      <= '0;
      end
      else
      begin
         tx_out_access <= st_access & ~mode_drop;
         drop_mode_q   <= st_access & mode_drop;   // pulse per lost packet
         if (st_access & ~mode_drop)
            sent_cnt <= sent_cnt + 8'd1;
      end
   end

   // payload reg
   always_ff @(posedge clk)
   begin
      if (st_access)
         tx_out_packet <= st_packet;
   end

   // ####################
   // pin levels
   // ####################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_pins  <= '0;
         tp_phase <= 1'b0;
      end
      else if (cfg.tp_enable)
      begin
         tx_pins  <= tp_phase ? TP_B : TP_A;
         tp_phase <= ~tp_phase;  // flip every cycle
      end
      else
      begin
         // phase parked so the next test run starts at 155
         tx_pins  <= cfg.gpio_enable ? cfg.gpio_data : 9'd0;
         tp_phase <= 1'b0;
      end
   end

   // remap bits are raised in etx_remap
   assign ev = '{count:         sent_cnt,
                 remapped:      1'b0,
                 drop_mode:     drop_mode_q,
                 drop_disabled: 1'b0};

endmodule

`default_nettype wire

// File: verilog/etx_top.sv
/*
 * mesh link transmit top
 * register file, execute stage and result stage
 */
`timescale 1ns/1ps
`default_nettype none

module etx_top #(
   parameter int          RFAW            = 6,
   parameter logic [11:0] DEFAULT_CHIPID  = 12'h808,
   parameter logic [15:0] DEFAULT_VERSION = 16'h0000
) (
   input  logic                   clk,
   input  logic                   reset,
   // memory interface
   input  logic                   mi_en,
   input  logic                   mi_we,
   input  logic [RFAW+1:0]        mi_addr,
   input  logic [31:0]            mi_din,
   output logic [31:0]            mi_dout,
   // mesh in, link out
   input  logic                   tx_in_access,
   input  etx_pkg::emesh_packet_t tx_in_packet,
   output logic                   tx_out_access,
   output etx_pkg::emesh_packet_t tx_out_packet,
   output logic [8:0]             tx_pins
);
   import etx_pkg::*;

   tx_cfg_t       cfg;
   logic          st_access;   // execute -> result
   emesh_packet_t st_packet;
   tx_event_t     ev_remap;
   tx_event_t     ev_pins;

   // decode
   etx_cfg #(
      .RFAW            (RFAW),
      .DEFAULT_CHIPID  (DEFAULT_CHIPID),
      .DEFAULT_VERSION (DEFAULT_VERSION)
   ) u_cfg (
      .clk      (clk),
      .reset    (reset),
      .mi_en    (mi_en),
      .mi_we    (mi_we),
      .mi_addr  (mi_addr),
      .mi_din   (mi_din),
      .mi_dout  (mi_dout),
      .cfg      (cfg),
      .ev_remap (ev_remap),
      .ev_pins  (ev_pins)
   );

   // execute
   etx_remap u_remap (
      .clk       (clk),
      .reset     (reset),
      .cfg       (cfg),
      .in_access (tx_in_access),
      .in_packet (tx_in_packet),
      .st_access (st_access),
      .st_packet (st_packet),
      .ev        (ev_remap)
   );

   // result
   etx_pins u_pins (
      .clk           (clk),
      .reset         (reset),
      .cfg           (cfg),
      .st_access     (st_access),
      .st_packet     (st_packet),
      .tx_out_access (tx_out_access),
      .tx_out_packet (tx_out_packet),
      .tx_pins       (tx_pins),
      .ev            (ev_pins)
   );

endmodule

`default_nettype wire

// File: sim/tb_etx.sv
/*
 * directed testbench for the mesh link transmit top
 * register access, drop / forward / remap, gpio and test pattern
 */
`timescale 1ns/1ps
`default_nettype none

`include "etx_regmap.svh"

module tb_etx;
   import etx_pkg::*;

   localparam int          RFAW        = 6;
   localparam logic [11:0] DEF_CHIPID  = 12'h808;
   localparam logic [15:0] DEF_VERSION = 16'h0000;
   localparam int          OUT_TIMEOUT = 20;  // cycles

   logic            clk;
   logic            reset;
   logic            mi_en;
   logic            mi_we;
   logic [RFAW+1:0] mi_addr;
   logic [31:0]     mi_din;
   logic [31:0]     mi_dout;
   logic            tx_in_access;
   emesh_packet_t   tx_in_packet;
   logic            tx_out_access;
   emesh_packet_t   tx_out_packet;
   logic [8:0]      tx_pins;

   integer          seed;
   int              cycle = 0;     // rising edges so far
   emesh_packet_t   exp_pkt_q[$];  // scoreboard
   int              exp_cyc_q[$];  // edge count when each one is due

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   etx_top #(.RFAW(RFAW), .DEFAULT_CHIPID(DEF_CHIPID), .DEFAULT_VERSION(DEF_VERSION)) DUT (
      .clk(clk), .reset(reset),
      .mi_en(mi_en), .mi_we(mi_we), .mi_addr(mi_addr), .mi_din(mi_din), .mi_dout(mi_dout),
      .tx_in_access(tx_in_access), .tx_in_packet(tx_in_packet),
      .tx_out_access(tx_out_access), .tx_out_packet(tx_out_packet), .tx_pins(tx_pins)
   );

   // ####################
   // checks
   // ####################

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic cmp_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic cmp_packet(input string name, input emesh_packet_t got,
                             input emesh_packet_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic cmp_pins(input string name, input logic [8:0] got, input logic [8:0] exp);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
   endtask

   // status word: sticky events low, sent count above
   function automatic logic [31:0] status_value(input int count, input logic [2:0] sticky);
      logic [7:0] cnt8;
      cnt8 = count[7:0];  // counter wraps at 256
      return {21'd0, cnt8, sticky};
   endfunction

   // ####################
   // drive tasks
   // ####################

   // all tasks start and end 2 ns after a rising edge
   task automatic mi_write(input logic [RFAW-1:0] idx, input logic [31:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {idx, 2'b11};  // byte bits must be ignored
      mi_din  = data;
      @(posedge clk);
      #2;
      mi_en   = 1'b0;
      mi_we   = 1'b0;
      mi_din  = '0;
   endtask

   task automatic mi_read(input logic [RFAW-1:0] idx, output logic [31:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = {idx, 2'b00};
      @(posedge clk);
      #2;
      mi_en   = 1'b0;
      data    = mi_dout;  // registered at the edge just passed
   endtask

   task automatic read_check(input logic [RFAW-1:0] idx, input logic [31:0] exp,
                             input string name);
      logic [31:0] val;
      mi_read(idx, val);
      cmp_word(name, val, exp);
   endtask

   task automatic random_packet(output emesh_packet_t p);
      p.write    = $random(seed);
      p.datamode = $random(seed);
      p.ctrlmode = $random(seed);
      p.dst_addr = $random(seed);
      p.data     = $random(seed);
      p.src_addr = $random(seed);
   endtask

   // one strobe, back to back when called in a row
   task automatic send_packet(input emesh_packet_t p);
      tx_in_access = 1'b1;
      tx_in_packet = p;
      @(posedge clk);
      #2;
      tx_in_access = 1'b0;
   endtask

   task automatic wait_out_access();
      int waited;
      waited = 0;
      @(posedge clk);
      #2;
      while (!tx_out_access && waited < OUT_TIMEOUT)
      begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (!tx_out_access)
         abort_run("timeout waiting for tx_out_access");
   endtask

   task automatic no_output_for(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #2;
         if (tx_out_access)
            abort_run("tx_out_access raised although the packet should be dropped");
      end
   endtask

   // pops the scoreboard, latency checked in edges
   task automatic check_outputs(input int n);
      repeat (n)
      begin
         wait_out_access();
         cmp_word("tx_out_access edge", cycle, exp_cyc_q.pop_front());
         cmp_packet("tx_out_packet", tx_out_packet, exp_pkt_q.pop_front());
      end
   endtask

   // sender and checker run side by side
   task automatic stream_packets(input int n, input logic remap, input logic [11:0] chipid,
                                 input logic bypass, input logic [3:0] ctrlmode);
      emesh_packet_t pkt;
      emesh_packet_t exp;
      fork
         repeat (n)
         begin
            random_packet(pkt);
            exp = pkt;
            if (remap)
               exp.dst_addr[31:20] = chipid;  // target chip replaced
            if (bypass)
               exp.ctrlmode = ctrlmode;
            exp_pkt_q.push_back(exp);
            exp_cyc_q.push_back(cycle + 2);  // two cycle latency
            send_packet(pkt);
         end
         check_outputs(n);
      join
      no_output_for(4);  // nothing extra behind them
   endtask

   // ####################
   // tests
   // ####################

   task automatic test_reset_regs();
      cmp_word("mi_dout", mi_dout, 32'd0);
      cmp_pins("tx_pins", tx_pins, 9'd0);
      cmp_word("tx_out_access", {31'd0, tx_out_access}, 32'd0);
      read_check(`E_VERSION, {16'd0, DEF_VERSION}, "version");
      read_check(`E_CHIPID, {20'd0, DEF_CHIPID}, "chipid");
      read_check(`ETX_CFG, 32'd0, "cfg");
      read_check(`ETX_STATUS, 32'd0, "status");
      read_check(`ETX_GPIO, 32'd0, "gpio");
      @(posedge clk);
      #2;
      cmp_word("mi_dout idle", mi_dout, 32'd0);  // only one cycle of readback
      mi_write(`E_VERSION, 32'hdead_beef);
      read_check(`E_VERSION, 32'h0000_beef, "version");
      mi_write(`E_CHIPID, 32'hffff_f123);
      read_check(`E_CHIPID, 32'h0000_0123, "chipid");
      mi_write(`ETX_CFG, 32'hffff_ffff);  // mode bits 11 = no pin mode
      read_check(`ETX_CFG, 32'h0000_07ff, "cfg");
      mi_write(`ETX_GPIO, 32'h5a5a_a1a5);
      read_check(`ETX_GPIO, 32'h0000_01a5, "gpio");
      mi_write(`ETX_STATUS, 32'hffff_ffff);  // read only
      read_check(`ETX_STATUS, 32'd0, "status");
      read_check(6'd5, 32'd0, "unmapped index 5");
      read_check(6'd63, 32'd0, "unmapped index 63");
      mi_write(`ETX_CFG, 32'd0);
      mi_write(`ETX_GPIO, 32'd0);
   endtask

   task automatic test_disabled_drop();
      emesh_packet_t pkt;
      repeat (3)
      begin
         random_packet(pkt);
         send_packet(pkt);
      end
      no_output_for(OUT_TIMEOUT);
      read_check(`ETX_STATUS, status_value(0, 3'b001), "status");
   endtask

   task automatic test_forward();
      mi_write(`ETX_CFG, 32'h0000_0001);  // tx on, nothing else
      stream_packets(8, 1'b0, 12'd0, 1'b0, 4'd0);
      cmp_pins("tx_pins", tx_pins, 9'd0);
      read_check(`ETX_STATUS, status_value(8, 3'b001), "status");
   endtask

   task automatic test_remap_bypass();
      mi_write(`E_CHIPID, 32'h0000_03c5);
      mi_write(`ETX_CFG, 32'h0000_01a5);  // tx, remap 01, ctrlmode a, bypass
      stream_packets(6, 1'b1, 12'h3c5, 1'b1, 4'ha);
      read_check(`ETX_STATUS, status_value(14, 3'b101), "status");
   endtask

   task automatic test_gpio_pattern();
      emesh_packet_t pkt;
      int i;
      mi_write(`ETX_GPIO, 32'h0000_013c);
      mi_write(`ETX_CFG, 32'h0000_0201);  // gpio mode
      @(posedge clk);
      #2;
      cmp_pins("tx_pins gpio", tx_pins, 9'h13c);
      random_packet(pkt);
      send_packet(pkt);
      no_output_for(OUT_TIMEOUT);
      cmp_pins("tx_pins gpio", tx_pins, 9'h13c);
      read_check(`ETX_STATUS, status_value(14, 3'b111), "status");
      mi_write(`ETX_CFG, 32'h0000_0401);  // test pattern
      for (i = 0; i < 8; i++)
      begin
         @(posedge clk);
         #2;
         cmp_pins("tx_pins pattern", tx_pins, (i % 2 == 0) ? 9'h155 : 9'h0aa);
      end
   endtask

   initial
   begin
      seed         = 32'h84b3_8b2e;
      reset        = 1'b1;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      mi_din       = '0;
      tx_in_access = 1'b0;
      tx_in_packet = '0;
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;
      test_reset_regs();
      test_disabled_drop();
      test_forward();
      test_remap_bypass();
      test_gpio_pattern();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
verilog/etx_pkg.sv
verilog/etx_cfg.sv
verilog/etx_remap.sv
verilog/etx_pins.sv
verilog/etx_top.sv
sim/tb_etx.sv

// File: Bender.yml
package:
  name: etx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/etx_pkg.sv
      - verilog/etx_cfg.sv
      - verilog/etx_remap.sv
      - verilog/etx_pins.sv
      - verilog/etx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_etx.sv
